// File: Makefile
# Verilator build and run for the physical register file testbench

TB_TOP = prf_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f sources.f --top-module prf_top

clean:
	rm -rf obj_dir

// File: common/prf_entry_if.sv
/*
 per-entry state shared by the free list, the value store and the read logic
 all signals are levels for the current cycle, there is no handshake
 values is a full copy of the storage, so readers index it directly
*/

`timescale 1ns/1ns

interface prf_entry_if;

	prf_pkg::prf_vec_t  available;                        // set means the entry is free
	prf_pkg::prf_vec_t  alloc_mask;                       // one-hot OR of this cycle's grants
	prf_pkg::prf_vec_t  ready;                            // set means the value has come back on a CDB
	prf_pkg::prf_data_t values [prf_pkg::PRF_SIZE];       // stored value of every entry

	// the free list owns availability and tells the store which entries it just gave out
	modport alloc_mp (
		output available,
		output alloc_mask
	);

	// the store clears ready on allocation and owns the data
	modport store_mp (
		input  alloc_mask,
		output ready,
		output values
	);

	modport read_mp (
		input  available,
		input  ready,
		input  values
	);

endinterface

// File: common/prf_pkg.sv
/*
 shared sizes and types for the physical register file
 one thread only, so there is a single free list and a single read set
 entry ZERO_REG_IDX is the hardwired zero register and is never handed out
 PRF_SIZE must stay a power of two so that prf_idx_t covers every entry
*/

package prf_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int PRF_SIZE     = 64;                // physical registers in the file
	localparam int DATA_WIDTH   = 64;                // width of one register value
	localparam int IDX_WIDTH    = $clog2(PRF_SIZE);  // bits needed to name an entry

	// the zero register reads as zero and valid and sits outside the free list
	localparam int ZERO_REG_IDX = 48;

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	// index of one physical register, as carried by rename, CDB and retire
	typedef logic [IDX_WIDTH-1:0] prf_idx_t;

	typedef logic [DATA_WIDTH-1:0] prf_data_t;   // one register value

	// one bit per entry, bit i belongs to physical register i
	// used for availability, ready bits, grant masks and the flush vector
	typedef logic [PRF_SIZE-1:0] prf_vec_t;

endpackage

// File: design/operand_read.sv
/*
 combinational operand and retire reads, two instructions with two sources each
 an operand is valid only when its entry is ready and still allocated
 an operand that is not valid returns its own index, zero-extended, as a tag
 the zero register always reads as zero and valid
 writeback_value is zero when the retiring entry holds no live value
*/

`timescale 1ns/1ns

module operand_read (
	input  prf_pkg::prf_idx_t    inst1_opa_idx,
	input  prf_pkg::prf_idx_t    inst1_opb_idx,
	input  prf_pkg::prf_idx_t    inst2_opa_idx,
	input  prf_pkg::prf_idx_t    inst2_opb_idx,
	input  prf_pkg::prf_idx_t    retire_idx,        // entry being retired by the ROB
	output prf_pkg::prf_data_t   inst1_opa_value,
	output prf_pkg::prf_data_t   inst1_opb_value,
	output prf_pkg::prf_data_t   inst2_opa_value,
	output prf_pkg::prf_data_t   inst2_opb_value,
	output logic                 inst1_opa_valid,
	output logic                 inst1_opb_valid,
	output logic                 inst2_opa_valid,
	output logic                 inst2_opb_valid,
	output prf_pkg::prf_data_t   writeback_value,
	prf_entry_if.read_mp         entry
);

	prf_pkg::prf_vec_t  live;          // ready and not sitting in the free list
	prf_pkg::prf_idx_t  op_idx [4];    // order is inst1 opa, inst1 opb, inst2 opa, inst2 opb
	prf_pkg::prf_data_t op_value [4];
	logic [3:0]         op_valid;

	// a freed entry may still have ready set until it is handed out again
	assign live = entry.ready & ~entry.available;

	assign op_idx[0] = inst1_opa_idx;
	assign op_idx[1] = inst1_opb_idx;
	assign op_idx[2] = inst2_opa_idx;
	assign op_idx[3] = inst2_opb_idx;

	always_comb
	begin
		for (int k = 0; k < 4; k++)
		begin
			if (op_idx[k] == prf_pkg::ZERO_REG_IDX)
			begin
				op_value[k] = '0;
				op_valid[k] = 1'b1;
			end
			else if (live[op_idx[k]])
			begin
				op_value[k] = entry.values[op_idx[k]];
				op_valid[k] = 1'b1;
			end
			else
			begin
				op_value[k] = prf_pkg::prf_data_t'(op_idx[k]);  // tag for the RS to wake on
				op_valid[k] = 1'b0;
			end
		end
	end

	assign inst1_opa_value = op_value[0];
	assign inst1_opb_value = op_value[1];
	assign inst2_opa_value = op_value[2];
	assign inst2_opb_value = op_value[3];
	assign inst1_opa_valid = op_valid[0];
	assign inst1_opb_valid = op_valid[1];
	assign inst2_opa_valid = op_valid[2];
	assign inst2_opb_valid = op_valid[3];

	// the zero register is never ready, so retiring it also gives zero
	assign writeback_value = live[retire_idx] ? entry.values[retire_idx] : '0;

endmodule

// File: design/prf_top.sv
/*
 physical register file top level for a single-thread renaming core
 grants are combinational and take effect at the next edge
 a CDB result is readable one cycle after its valid
 a refused allocation is dropped and has to be retried by rename
*/

`timescale 1ns/1ns

module prf_top (
	input  logic                 clock,
	input  logic                 rst,

	// rename allocation
	input  logic                 alloc_req1,
	input  logic                 alloc_req2,
	output logic                 alloc_valid1,
	output prf_pkg::prf_idx_t    alloc_idx1,
	output logic                 alloc_valid2,
	output prf_pkg::prf_idx_t    alloc_idx2,
	output logic                 prf_full,

	// result broadcast
	input  logic                 cdb1_valid,
	input  prf_pkg::prf_idx_t    cdb1_tag,
	input  prf_pkg::prf_data_t   cdb1_value,
	input  logic                 cdb2_valid,
	input  prf_pkg::prf_idx_t    cdb2_tag,
	input  prf_pkg::prf_data_t   cdb2_value,

	// operand reads for two instructions
	input  prf_pkg::prf_idx_t    inst1_opa_idx,
	input  prf_pkg::prf_idx_t    inst1_opb_idx,
	input  prf_pkg::prf_idx_t    inst2_opa_idx,
	input  prf_pkg::prf_idx_t    inst2_opb_idx,
	output prf_pkg::prf_data_t   inst1_opa_value,
	output prf_pkg::prf_data_t   inst1_opb_value,
	output prf_pkg::prf_data_t   inst2_opa_value,
	output prf_pkg::prf_data_t   inst2_opb_value,
	output logic                 inst1_opa_valid,
	output logic                 inst1_opb_valid,
	output logic                 inst2_opa_valid,
	output logic                 inst2_opb_valid,

	// retirement and mispredict recovery
	input  logic                 free1_valid,
	input  prf_pkg::prf_idx_t    free1_idx,
	input  logic                 free2_valid,
	input  prf_pkg::prf_idx_t    free2_idx,
	input  logic                 flush_valid,
	input  prf_pkg::prf_vec_t    flush_free_list,
	input  prf_pkg::prf_idx_t    retire_idx,
	output prf_pkg::prf_data_t   writeback_value
);

	prf_entry_if entry_if ();

	free_list free_list_i (
		.clock, .rst,
		.alloc_req1, .alloc_req2,
		.free1_valid, .free1_idx, .free2_valid, .free2_idx,
		.flush_valid, .flush_free_list,
		.alloc_valid1, .alloc_idx1, .alloc_valid2, .alloc_idx2,
		.prf_full,
		.entry (entry_if.alloc_mp)
	);

	value_store value_store_i (
		.clock, .rst,
		.cdb1_valid, .cdb1_tag, .cdb1_value,
		.cdb2_valid, .cdb2_tag, .cdb2_value,
		.entry (entry_if.store_mp)
	);

	operand_read operand_read_i (
		.inst1_opa_idx, .inst1_opb_idx, .inst2_opa_idx, .inst2_opb_idx,
		.retire_idx,
		.inst1_opa_value, .inst1_opb_value, .inst2_opa_value, .inst2_opb_value,
		.inst1_opa_valid, .inst1_opb_valid, .inst2_opa_valid, .inst2_opb_valid,
		.writeback_value,
		.entry (entry_if.read_mp)
	);

endmodule

// File: free_list/free_list.sv
/*
 availability tracking and up to two grants per cycle, lowest free index first
 a dual request with only one entry left is refused as a whole and raises prf_full
 a single request on either port takes the lowest free entry
 frees from retirement and from the flush vector land at the next edge
 if a free and a grant name the same entry in one cycle the grant wins
*/

`timescale 1ns/1ns

module free_list (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 alloc_req1,        // rename asks for one entry on port 1
	input  logic                 alloc_req2,        // rename asks for one entry on port 2
	input  logic                 free1_valid,       // retirement frees free1_idx
	input  prf_pkg::prf_idx_t    free1_idx,
	input  logic                 free2_valid,
	input  prf_pkg::prf_idx_t    free2_idx,
	input  logic                 flush_valid,       // mispredict, every marked entry is freed
	input  prf_pkg::prf_vec_t    flush_free_list,
	output logic                 alloc_valid1,
	output prf_pkg::prf_idx_t    alloc_idx1,
	output logic                 alloc_valid2,
	output prf_pkg::prf_idx_t    alloc_idx2,
	output logic                 prf_full,
	prf_entry_if.alloc_mp        entry
);

	prf_pkg::prf_vec_t avail_q;     // registered availability, one bit per entry
	prf_pkg::prf_vec_t avail_rest;  // what is left once the first pick is taken
	prf_pkg::prf_vec_t free_mask;   // all frees requested this cycle
	prf_pkg::prf_idx_t pick1;       // lowest free entry
	prf_pkg::prf_idx_t pick2;       // next lowest free entry
	logic              have1;
	logic              have2;
	logic              leave_one;   // exactly one entry is free
	logic              dual_refused;

	// scan from the top down so the last hit is the lowest set bit
	function automatic prf_pkg::prf_idx_t lowest_set(prf_pkg::prf_vec_t v);
		prf_pkg::prf_idx_t idx;
		idx = '0;
		for (int i = prf_pkg::PRF_SIZE - 1; i >= 0; i--)
		begin
			if (v[i])
				idx = prf_pkg::prf_idx_t'(i);
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// priority picks
	////////////////////////////////////////////////////////////////////////////

	assign have1      = |avail_q;
	assign pick1      = lowest_set(avail_q);
	assign avail_rest = avail_q & ~(prf_pkg::prf_vec_t'(1) << pick1);
	assign have2      = |avail_rest;
	assign pick2      = lowest_set(avail_rest);
	assign leave_one  = have1 && !have2;

	always_comb
	begin
		alloc_valid1 = 1'b0;
		alloc_idx1   = '0;
		alloc_valid2 = 1'b0;
		alloc_idx2   = '0;
		dual_refused = 1'b0;
		if (alloc_req1 && alloc_req2)
		begin
			// both or nothing, a half grant would leave rename with one new tag
			if (leave_one)
				dual_refused = 1'b1;
			else
			begin
				alloc_valid1 = have1;
				alloc_idx1   = pick1;
				alloc_valid2 = have2;
				alloc_idx2   = pick2;
			end
		end
		else if (alloc_req1)
		begin
			alloc_valid1 = have1;
			alloc_idx1   = pick1;
		end
		else if (alloc_req2)
		begin
			alloc_valid2 = have1;   // a lone port 2 request still takes the lowest entry
			alloc_idx2   = pick1;
		end
	end

	assign prf_full = !have1 || dual_refused;

	assign entry.alloc_mask = (alloc_valid1 ? prf_pkg::prf_vec_t'(1) << alloc_idx1 : '0)
		| (alloc_valid2 ? prf_pkg::prf_vec_t'(1) << alloc_idx2 : '0);
	assign entry.available  = avail_q;

	////////////////////////////////////////////////////////////////////////////
	// availability update
	////////////////////////////////////////////////////////////////////////////

	assign free_mask = (free1_valid ? prf_pkg::prf_vec_t'(1) << free1_idx : '0)
		| (free2_valid ? prf_pkg::prf_vec_t'(1) << free2_idx : '0)
		| (flush_valid ? flush_free_list : '0);

	always_ff @(posedge clock)
	begin
		if (rst)
			avail_q <= ~(prf_pkg::prf_vec_t'(1) << prf_pkg::ZERO_REG_IDX);  // all but zero reg
		else
			avail_q <= (avail_q | free_mask) & ~entry.alloc_mask;  // grant beats free
	end

	// the two ports must never hand the same tag to two architectural registers
	a_grants_distinct: assert property (@(posedge clock) disable iff (rst)
		(alloc_valid1 && alloc_valid2) |-> (alloc_idx1 != alloc_idx2));

	// the RRAT and the flush logic must keep the zero register out of the free list
	a_zero_never_freed: assert property (@(posedge clock) disable iff (rst)
		!((free1_valid && free1_idx == prf_pkg::ZERO_REG_IDX)
		|| (free2_valid && free2_idx == prf_pkg::ZERO_REG_IDX)
		|| (flush_valid && flush_free_list[prf_pkg::ZERO_REG_IDX])));

endmodule

// File: sources.f
common/prf_pkg.sv
common/prf_entry_if.sv
free_list/free_list.sv
value_store/value_store.sv
design/operand_read.sv
design/prf_top.sv
testbench/prf_tb.sv

// File: testbench/prf_tb.sv
/*
 directed testbench for the physical register file top level
 a scoreboard of available, ready and value per entry predicts each response
 inputs change on the rising edge and outputs are sampled on the falling edge
 the tests run in a fixed order and each one starts from the state the last left
 rename only asks on port 2 together with port 1 here
*/

`timescale 1ns/1ns

module prf_tb;

	localparam int CLK_PERIOD  = 20;
	localparam int TEST_CYCLES = 400;   // rough sum of all test lengths in cycles
	localparam int ZERO        = prf_pkg::ZERO_REG_IDX;

	logic               clock;
	logic               rst;
	logic               alloc_req1, alloc_req2, alloc_valid1, alloc_valid2, prf_full;
	prf_pkg::prf_idx_t  alloc_idx1, alloc_idx2;
	logic               cdb1_valid, cdb2_valid;
	prf_pkg::prf_idx_t  cdb1_tag, cdb2_tag;
	prf_pkg::prf_data_t cdb1_value, cdb2_value;
	prf_pkg::prf_idx_t  inst1_opa_idx, inst1_opb_idx, inst2_opa_idx, inst2_opb_idx;
	prf_pkg::prf_data_t inst1_opa_value, inst1_opb_value, inst2_opa_value, inst2_opb_value;
	logic               inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid;
	logic               free1_valid, free2_valid, flush_valid;
	prf_pkg::prf_idx_t  free1_idx, free2_idx, retire_idx;
	prf_pkg::prf_vec_t  flush_free_list;
	prf_pkg::prf_data_t writeback_value;

	// scoreboard, one slot per physical register
	logic               avail_m [prf_pkg::PRF_SIZE];
	logic               ready_m [prf_pkg::PRF_SIZE];
	prf_pkg::prf_data_t value_m [prf_pkg::PRF_SIZE];
	int                 errors = 0;
	int                 checks = 0;

	prf_top prf_top_i (.*);

	initial clock = 1'b0;
	always #(CLK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// compare helpers and model lookups
	////////////////////////////////////////////////////////////////////////////

	task automatic check_bit(string what, logic got, logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	task automatic check_data(string what, prf_pkg::prf_data_t got, prf_pkg::prf_data_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_int(string what, int got, int exp);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	function automatic int free_count();
		int n;
		n = 0;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
			n += int'(avail_m[i]);
		return n;
	endfunction

	// lowest free entry other than skip, -1 when there is none
	function automatic int lowest_free(int skip);
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (avail_m[i] && i != skip)
				return i;
		end
		return -1;
	endfunction

	function automatic logic operand_valid_expect(prf_pkg::prf_idx_t idx);
		return int'(idx) == ZERO || (ready_m[idx] && !avail_m[idx]);
	endfunction

	function automatic prf_pkg::prf_data_t operand_expect(prf_pkg::prf_idx_t idx);
		if (int'(idx) == ZERO)
			return '0;
		if (ready_m[idx] && !avail_m[idx])
			return value_m[idx];
		return prf_pkg::prf_data_t'(idx);   // a waiting operand hands back its tag
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus operations, each drives one request cycle and then goes idle
	////////////////////////////////////////////////////////////////////////////

	task automatic allocate(input logic dual, output int g1, output int g2);
		int   n;
		int   e1;
		int   e2;
		logic ev1;
		logic ev2;
		n   = free_count();
		e1  = lowest_free(-1);
		e2  = lowest_free(e1);
		ev1 = n >= 1 && !(dual && n == 1);   // a pair with one entry left is refused whole
		ev2 = dual && n >= 2;
		@(posedge clock);
		alloc_req1 <= 1'b1;
		alloc_req2 <= dual;
		@(negedge clock);
		check_bit("alloc_valid1", alloc_valid1, ev1);
		check_bit("alloc_valid2", alloc_valid2, ev2);
		check_bit("prf_full", prf_full, n == 0 || (dual && n == 1));
		if (ev1)
			check_int("alloc_idx1", int'(alloc_idx1), e1);
		if (ev2)
			check_int("alloc_idx2", int'(alloc_idx2), e2);
		g1 = ev1 ? e1 : -1;
		g2 = ev2 ? e2 : -1;
		@(posedge clock);
		alloc_req1 <= 1'b0;
		alloc_req2 <= 1'b0;
		if (ev1)
		begin
			avail_m[e1] = 1'b0;
			ready_m[e1] = 1'b0;
		end
		if (ev2)
		begin
			avail_m[e2] = 1'b0;
			ready_m[e2] = 1'b0;
		end
	endtask

	task automatic cdb_write(logic v1, prf_pkg::prf_idx_t t1, prf_pkg::prf_data_t d1,
		logic v2, prf_pkg::prf_idx_t t2, prf_pkg::prf_data_t d2);
		@(posedge clock);
		cdb1_valid <= v1;
		cdb1_tag   <= t1;
		cdb1_value <= d1;
		cdb2_valid <= v2;
		cdb2_tag   <= t2;
		cdb2_value <= d2;
		@(posedge clock);
		cdb1_valid <= 1'b0;
		cdb2_valid <= 1'b0;
		if (v1)
		begin
			ready_m[t1] = 1'b1;
			value_m[t1] = d1;
		end
		if (v2)
		begin
			ready_m[t2] = 1'b1;
			value_m[t2] = d2;   // applied last so cdb2 keeps a shared tag
		end
	endtask

	task automatic read_operands(prf_pkg::prf_idx_t a, prf_pkg::prf_idx_t b,
		prf_pkg::prf_idx_t c, prf_pkg::prf_idx_t d);
		@(posedge clock);
		inst1_opa_idx <= a;
		inst1_opb_idx <= b;
		inst2_opa_idx <= c;
		inst2_opb_idx <= d;
		@(negedge clock);
		check_data("inst1_opa_value", inst1_opa_value, operand_expect(a));
		check_bit("inst1_opa_valid", inst1_opa_valid, operand_valid_expect(a));
		check_data("inst1_opb_value", inst1_opb_value, operand_expect(b));
		check_bit("inst1_opb_valid", inst1_opb_valid, operand_valid_expect(b));
		check_data("inst2_opa_value", inst2_opa_value, operand_expect(c));
		check_bit("inst2_opa_valid", inst2_opa_valid, operand_valid_expect(c));
		check_data("inst2_opb_value", inst2_opb_value, operand_expect(d));
		check_bit("inst2_opb_valid", inst2_opb_valid, operand_valid_expect(d));
	endtask

	task automatic retire_check(prf_pkg::prf_idx_t idx);
		@(posedge clock);
		retire_idx <= idx;
		@(negedge clock);
		check_data("writeback_value", writeback_value,
			(ready_m[idx] && !avail_m[idx]) ? value_m[idx] : '0);
	endtask

	task automatic free_entries(logic v1, prf_pkg::prf_idx_t i1, logic v2,
		prf_pkg::prf_idx_t i2, logic fv, prf_pkg::prf_vec_t fl);
		@(posedge clock);
		free1_valid     <= v1;
		free1_idx       <= i1;
		free2_valid     <= v2;
		free2_idx       <= i2;
		flush_valid     <= fv;
		flush_free_list <= fl;
		@(posedge clock);
		free1_valid <= 1'b0;
		free2_valid <= 1'b0;
		flush_valid <= 1'b0;
		if (v1)
			avail_m[i1] = 1'b1;
		if (v2)
			avail_m[i2] = 1'b1;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (fv && fl[i])
				avail_m[i] = 1'b1;   // ready is kept, reads mask it with availability
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_alloc();
		int g1;
		int g2;
		allocate(1'b1, g1, g2);
		check_int("first pair grant 1", g1, 0);
		check_int("first pair grant 2", g2, 1);
		allocate(1'b0, g1, g2);
		check_int("single grant", g1, 2);
	endtask

	task automatic test_not_ready();
		read_operands(6'd0, 6'd1, 6'd2, 6'd5);   // entry 5 is still free
	endtask

	task automatic test_cdb_writes();
		prf_pkg::prf_data_t d1;
		prf_pkg::prf_data_t d2;
		d1 = {$urandom, $urandom};
		d2 = {$urandom, $urandom};
		cdb_write(1'b1, 6'd0, d1, 1'b1, 6'd1, d2);
		read_operands(6'd0, 6'd1, 6'd1, 6'd0);
		d1 = {$urandom, $urandom};
		d2 = {$urandom, $urandom};
		cdb_write(1'b1, 6'd2, d1, 1'b1, 6'd2, d2);   // same tag on both buses
		read_operands(6'd2, 6'd2, 6'd0, 6'd1);
		check_data("shared tag value", inst1_opa_value, d2);
	endtask

	task automatic test_zero_reg();
		read_operands(prf_pkg::prf_idx_t'(ZERO), prf_pkg::prf_idx_t'(ZERO),
			prf_pkg::prf_idx_t'(ZERO), prf_pkg::prf_idx_t'(ZERO));
	endtask

	task automatic test_retire_free();
		int g1;
		int g2;
		retire_check(6'd1);
		retire_check(6'd5);
		retire_check(prf_pkg::prf_idx_t'(ZERO));
		free_entries(1'b1, 6'd1, 1'b1, 6'd0, 1'b0, '0);
		allocate(1'b1, g1, g2);
		check_int("pair after retire grant 1", g1, 0);
		check_int("pair after retire grant 2", g2, 1);
		free_entries(1'b0, 6'd0, 1'b0, 6'd0, 1'b1, prf_pkg::prf_vec_t'(7));
		read_operands(6'd0, 6'd1, 6'd2, 6'd2);   // flushed entries no longer read valid
		allocate(1'b1, g1, g2);
		check_int("pair after flush grant 1", g1, 0);
		check_int("pair after flush grant 2", g2, 1);
		allocate(1'b0, g1, g2);
		check_int("single after flush", g1, 2);
	endtask

	task automatic test_exhaustion();
		int g1;
		int g2;
		if (free_count() % 2 == 0)
			allocate(1'b0, g1, g2);   // make pairs end on exactly one free entry
		while (free_count() > 1)
			allocate(1'b1, g1, g2);
		allocate(1'b1, g1, g2);
		check_int("refused pair grant", g1, -1);
		allocate(1'b0, g1, g2);
		// grants go lowest first, so the top entry is the one left over
		check_int("last entry", g1, prf_pkg::PRF_SIZE - 1);
		@(negedge clock);
		check_bit("prf_full when empty", prf_full, 1'b1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		#((TEST_CYCLES + TEST_CYCLES / 4) * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in %0d cycles",
			TEST_CYCLES + TEST_CYCLES / 4);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		void'($urandom(94));
		rst             <= 1'b1;
		alloc_req1      <= 1'b0;
		alloc_req2      <= 1'b0;
		cdb1_valid      <= 1'b0;
		cdb1_tag        <= '0;
		cdb1_value      <= '0;
		cdb2_valid      <= 1'b0;
		cdb2_tag        <= '0;
		cdb2_value      <= '0;
		inst1_opa_idx   <= '0;
		inst1_opb_idx   <= '0;
		inst2_opa_idx   <= '0;
		inst2_opb_idx   <= '0;
		free1_valid     <= 1'b0;
		free1_idx       <= '0;
		free2_valid     <= 1'b0;
		free2_idx       <= '0;
		flush_valid     <= 1'b0;
		flush_free_list <= '0;
		retire_idx      <= '0;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			avail_m[i] = (i != ZERO);   // everything but the zero register starts free
			ready_m[i] = 1'b0;
			value_m[i] = '0;
		end
		repeat (10) @(posedge clock);
		rst <= 1'b0;
		test_reset_alloc();
		test_not_ready();
		test_cdb_writes();
		test_zero_reg();
		test_retire_free();
		test_exhaustion();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: value_store/value_store.sv
/*
 entry values and ready bits, written from two CDB ports
 when both CDBs carry the same tag in one cycle the cdb2 value is kept
 allocation clears ready at the next edge and takes priority over a CDB write
 the zero register is never written, its value comes from the read logic
*/

`timescale 1ns/1ns

module value_store (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 cdb1_valid,
	input  prf_pkg::prf_idx_t    cdb1_tag,
	input  prf_pkg::prf_data_t   cdb1_value,
	input  logic                 cdb2_valid,
	input  prf_pkg::prf_idx_t    cdb2_tag,
	input  prf_pkg::prf_data_t   cdb2_value,
	prf_entry_if.store_mp        entry
);

	prf_pkg::prf_data_t mem [prf_pkg::PRF_SIZE];   // one value per physical register
	prf_pkg::prf_vec_t  ready_q;
	prf_pkg::prf_vec_t  cdb1_hit;                  // one-hot entry written by cdb1
	prf_pkg::prf_vec_t  cdb2_hit;

	assign cdb1_hit = cdb1_valid ? prf_pkg::prf_vec_t'(1) << cdb1_tag : '0;
	assign cdb2_hit = cdb2_valid ? prf_pkg::prf_vec_t'(1) << cdb2_tag : '0;

	////////////////////////////////////////////////////////////////////////////
	// ready bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
			ready_q <= '0;   // nothing has produced a result yet
		else
			ready_q <= (ready_q | cdb1_hit | cdb2_hit) & ~entry.alloc_mask;
	end

	// result values from both CDBs land in the entry named by their tag
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (cdb2_hit[i])
				mem[i] <= cdb2_value;   // cdb2 checked first so it wins a shared tag
			else if (cdb1_hit[i])
				mem[i] <= cdb1_value;
		end
	end

	assign entry.ready  = ready_q;
	assign entry.values = mem;

	// a functional unit must never broadcast a result for the zero register
	a_cdb_not_zero: assert property (@(posedge clock) disable iff (rst)
		!((cdb1_valid && cdb1_tag == prf_pkg::ZERO_REG_IDX)
		|| (cdb2_valid && cdb2_tag == prf_pkg::ZERO_REG_IDX)));

endmodule
